/* Makefile */
# Verilator build and run for the multicycle core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
common/core_pkg.sv
verilog/pc_counter.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/lsu_align.sv
verilog/core_ctrl_fsm.sv
verilog/core_top.sv
verif/core_props.sv
verif/core_tb.sv

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  strb_t;

    // RV32I major opcodes in the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT, PASS_B} alu_op_e;

    typedef enum logic [3:0] {
        ALU_REG, ALU_IMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, SYSTEM, ILLEGAL
    } op_class_e;

    typedef enum logic [2:0] {FETCH, EXEC, MEM, WB, HALT} ctrl_state_e;

    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        xlen_t wdata;
        strb_t strb;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        xlen_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        op_class_e op;
        alu_op_e   alu_op;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        xlen_t     imm;
        logic [2:0] funct3;
        logic      reg_write;
    } decode_t;

endpackage

`default_nettype wire

/* verif/core_patterns.hex */
// Words 0x00..: program image, eight instructions per line
// Words 0x40..: store records as address, write data, strobe; word 0xff: store count
@00
123450b7 67808093 10000513 ff000113 002081b3 00352023 40208233 00452223
0020f2b3 0020e333 00552423 00652623 0020c3b3 00112433 fff0a493 00752823
00852a23 00952c23 0a500593 02b50023 02b500a3 02b50123 02b501a3 02250603
02354683 02c52223 02d52423 02052703 02e52623 04d00793 00108463 04f52023
00208463 00180813 00209463 04f52023 00109463 00180813 00114463 04f52023
0020c463 00180813 0020d463 04f52023 00115463 00180813 03052823 008008ef
04f52023 03152a23 0d400913 001909e7 04f52023 03352c23 00001a17 03452e23
fff0ca93 0ff0fb13 700b6b13 05552223 05652423 00000073
@40
00000100 12345668 0000000f
00000104 12345688 0000000f
00000108 12345670 0000000f
0000010c fffffff8 0000000f
00000110 edcba988 0000000f
00000114 00000001 0000000f
00000118 00000000 0000000f
00000120 a5a5a5a5 00000001
00000120 a5a5a5a5 00000002
00000120 a5a5a5a5 00000004
00000120 a5a5a5a5 00000008
00000124 ffffffa5 0000000f
00000128 000000a5 0000000f
0000012c a5a5a5a5 0000000f
00000130 00000004 0000000f
00000134 000000c0 0000000f
00000138 000000d0 0000000f
0000013c 000010d8 0000000f
00000144 edcba987 0000000f
00000148 00000778 0000000f
@ff
00000014

/* verif/core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module core_props import core_pkg::*; (
    input logic     clock,
    input logic     rst_i,
    input mem_req_t req_i,
    input mem_rsp_t rsp_i,
    input logic     halt_i
);

    // A waiting request holds every field until ready
    property req_held;
        @(posedge clock) disable iff (rst_i)
            (req_i.valid && !rsp_i.ready) |=> $stable(req_i);
    endproperty

    property quiet_after_halt;
        @(posedge clock) disable iff (rst_i)
            halt_i |-> !req_i.valid;
    endproperty

    // Only a reset clears halt
    property halt_sticky;
        @(posedge clock) $fell(halt_i) |-> $past(rst_i);
    endproperty

    held_chk: assert property (req_held)
        else $error("Bus request changed while waiting for ready");
    quiet_chk: assert property (quiet_after_halt)
        else $error("Bus request valid while halted");
    sticky_chk: assert property (halt_sticky)
        else $error("Halt dropped without reset");

endmodule

`default_nettype wire

/* verif/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int PAT_WORDS = 256;
    localparam int PROG_MAX  = 64;
    localparam int REC_BASE  = 'h40;
    localparam int COUNT_IDX = 'hff;
    localparam int MEM_WORDS = 128;
    localparam int HALT_WAIT = 8;
    localparam logic [31:0] SEED = 32'hd03bcd85;

    logic     clock;
    logic     rst_i;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     halt;

    xlen_t patterns [0:PAT_WORDS-1];
    xlen_t mem [0:MEM_WORDS-1];
    int    prog_len = 0;
    int    exp_count = 0;
    int    watch_cycles = 0;
    int    store_count = 0;
    int    value_errors = 0;
    int    other_errors = 0;

    core_top #(
        .RESET_PC (32'h0000_0000)
    ) uut (
        .clock     (clock),
        .rst_i     (rst_i),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp),
        .halt_o    (halt)
    );

    bind core_top core_props u_props (
        .clock  (clock),
        .rst_i  (rst_i),
        .req_i  (mem_req_o),
        .rsp_i  (mem_rsp_i),
        .halt_i (halt_o)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Program at word 0, store records of addr/data/strb from REC_BASE, count last
    task automatic load_patterns();
        for (int i = 0; i < PAT_WORDS; i++) begin
            patterns[i] = '0;
        end
        $readmemh("verif/core_patterns.hex", patterns);
        while (prog_len < PROG_MAX && patterns[prog_len] != '0) begin
            prog_len++;
        end
        exp_count    = int'(patterns[COUNT_IDX]);
        watch_cycles = (prog_len > 0 ? prog_len : 1) * 50;
    endtask

    task automatic check_store(input mem_req_t req);
        int    base;
        addr_t exp_addr;
        xlen_t exp_data;
        strb_t exp_strb;
        assert (store_count < exp_count)
        else begin
            $display("Extra store to address %08h at %0t beyond the expected %0d",
                     req.addr, $time, exp_count);
            other_errors++;
        end
        if (store_count < exp_count) begin
            base     = REC_BASE + 3 * store_count;
            exp_addr = patterns[base];
            exp_data = patterns[base + 1];
            exp_strb = patterns[base + 2][3:0];
            assert (req.addr == exp_addr && req.wdata == exp_data && req.strb == exp_strb)
            else begin
                $display("FAILED at %0t: store %0d got %08h/%08h/%h, expected %08h/%08h/%h",
                         $time, store_count, req.addr, req.wdata, req.strb,
                         exp_addr, exp_data, exp_strb);
                value_errors++;
            end
        end
        store_count++;
    endtask

    task automatic write_mem(input int idx, input mem_req_t req);
        for (int b = 0; b < 4; b++) begin
            if (req.strb[b]) begin
                mem[idx][8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
    endtask

    // Memory model with random wait states
    initial begin : responder
        mem_req_t    req;
        logic [31:0] rand_state;
        int          delay;
        int          idx;
        logic        in_range;
        mem_rsp    = '0;
        rand_state = SEED;
        wait (watch_cycles > 0);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i < PROG_MAX) ? patterns[i] : '0;
        end
        forever begin
            @(negedge clock);
            if (!rst_i && halt) begin
                assert (!mem_req.valid)
                else begin
                    $display("Bus request issued after halt at %0t", $time);
                    other_errors++;
                end
            end
            if (!rst_i && mem_req.valid) begin
                req        = mem_req;
                rand_state = lcg_next(rand_state);
                delay      = int'(rand_state[17:16]);
                idx        = int'(req.addr[31:2]);
                in_range   = idx < MEM_WORDS;
                assert (in_range)
                else begin
                    $display("Access outside memory at address %08h", req.addr);
                    other_errors++;
                end
                repeat (delay) @(posedge clock);
                @(posedge clock);
                #1;
                mem_rsp.ready = 1'b1;
                mem_rsp.rdata = in_range ? mem[idx] : '0;
                @(posedge clock);
                if (req.we) begin
                    check_store(req);
                    if (in_range) begin
                        write_mem(idx, req);
                    end
                end
                #1;
                mem_rsp = '0;
            end
        end
    end

    initial begin : watchdog
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clock);
        $display("Timeout, the core did not halt within %0d cycles", watch_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        logic count_error;
        $timeformat(-9, 0, " ns", 0);
        count_error = 1'b0;
        rst_i       = 1'b1;
        load_patterns();
        assert (prog_len > 0)
        else begin
            $display("Pattern file holds no program");
            count_error = 1'b1;
        end
        repeat (4) @(posedge clock);
        #1;
        rst_i = 1'b0;
        while (!halt) @(negedge clock);
        // Window to catch requests after ecall
        repeat (HALT_WAIT) @(negedge clock);
        assert (store_count == exp_count)
        else begin
            $display("FAILED at %0t: observed %0d stores, expected %0d",
                     $time, store_count, exp_count);
            count_error = 1'b1;
        end
        $display("Stores %0d of %0d, value errors %0d, other errors %0d, count error %0d",
                 store_count, exp_count, value_errors, other_errors, count_error);
        if (value_errors == 0 && other_errors == 0 && !count_error) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/core_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_fsm import core_pkg::*; (
    input  logic    clock,
    input  logic    rst_i,
    input  decode_t dec_i,
    input  logic    taken_i,
    input  logic    bus_done_i,
    output logic    fetch_req_o,
    output logic    data_req_o,
    output logic    ir_load_o,
    output logic    pc_step_o,
    output logic    pc_jump_o,
    output logic    reg_wen_o,
    output logic    halt_o
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        is_mem_op;
    logic        is_jump;

    assign is_mem_op = (dec_i.op == LOAD) || (dec_i.op == STORE);
    assign is_jump   = (dec_i.op == JAL) || (dec_i.op == JALR) ||
                       ((dec_i.op == BRANCH) && taken_i);

    always_ff @(posedge clock) begin
        if (rst_i) begin
            state <= FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt   = state;
        fetch_req_o = 1'b0;
        data_req_o  = 1'b0;
        ir_load_o   = 1'b0;
        pc_step_o   = 1'b0;
        pc_jump_o   = 1'b0;
        reg_wen_o   = 1'b0;
        halt_o      = 1'b0;
        case (state)
            FETCH: begin
                fetch_req_o = 1'b1;
                if (bus_done_i) begin
                    ir_load_o = 1'b1;
                    state_nxt = EXEC;
                end
            end
            EXEC: begin
                if (dec_i.op == SYSTEM || dec_i.op == ILLEGAL) begin
                    state_nxt = HALT;
                end else if (is_mem_op) begin
                    state_nxt = MEM;
                end else begin
                    state_nxt = WB;
                end
            end
            MEM: begin
                data_req_o = 1'b1;
                if (bus_done_i) begin
                    state_nxt = WB;
                end
            end
            WB: begin
                reg_wen_o = dec_i.reg_write;
                pc_jump_o = is_jump;
                pc_step_o = !is_jump;
                state_nxt = FETCH;
            end
            default: begin
                // Only reset leaves this state
                halt_o    = 1'b1;
                state_nxt = HALT;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic     clock,
    input  logic     rst_i,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i,
    output logic     halt_o
);

    decode_t dec;
    logic    taken;
    logic    bus_done;
    logic    fetch_req;
    logic    data_req;
    logic    ir_load;
    logic    pc_step;
    logic    pc_jump;
    logic    reg_wen;
    addr_t   pc;
    addr_t   target;
    xlen_t   rs1_data;
    xlen_t   rs2_data;
    xlen_t   result;
    xlen_t   wb_data;
    inst_t   inst;

    core_ctrl_fsm u_ctrl (
        .clock       (clock),
        .rst_i       (rst_i),
        .dec_i       (dec),
        .taken_i     (taken),
        .bus_done_i  (bus_done),
        .fetch_req_o (fetch_req),
        .data_req_o  (data_req),
        .ir_load_o   (ir_load),
        .pc_step_o   (pc_step),
        .pc_jump_o   (pc_jump),
        .reg_wen_o   (reg_wen),
        .halt_o      (halt_o)
    );

    pc_counter #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clock    (clock),
        .rst_i    (rst_i),
        .step_i   (pc_step),
        .jump_i   (pc_jump),
        .target_i (target),
        .pc_o     (pc)
    );

    inst_decoder u_dec (
        .clock  (clock),
        .rst_i  (rst_i),
        .load_i (ir_load),
        .inst_i (inst),
        .dec_o  (dec)
    );

    reg_file u_rf (
        .clock      (clock),
        .rst_i      (rst_i),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rd_i       (dec.rd),
        .wen_i      (reg_wen),
        .wdata_i    (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exec_unit u_exec (
        .dec_i      (dec),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (result),
        .target_o   (target),
        .taken_o    (taken)
    );

    lsu_align u_lsu (
        .clock        (clock),
        .rst_i        (rst_i),
        .fetch_req_i  (fetch_req),
        .data_req_i   (data_req),
        .pc_i         (pc),
        .dec_i        (dec),
        .addr_i       (target),
        .store_data_i (rs2_data),
        .result_i     (result),
        .mem_rsp_i    (mem_rsp_i),
        .mem_req_o    (mem_req_o),
        .bus_done_o   (bus_done),
        .inst_o       (inst),
        .wb_data_o    (wb_data)
    );

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import core_pkg::*; (
    input  decode_t dec_i,
    input  addr_t   pc_i,
    input  xlen_t   rs1_data_i,
    input  xlen_t   rs2_data_i,
    output xlen_t   result_o,
    output addr_t   target_o,
    output logic    taken_o
);

    xlen_t op_b;
    xlen_t alu_out;
    addr_t rs1_sum;
    logic  is_eq;
    logic  is_lt;

    assign op_b    = (dec_i.op == ALU_REG || dec_i.op == BRANCH) ? rs2_data_i : dec_i.imm;
    assign rs1_sum = rs1_data_i + dec_i.imm;

    always_comb begin
        case (dec_i.alu_op)
            SUB:     alu_out = rs1_data_i - op_b;
            AND:     alu_out = rs1_data_i & op_b;
            OR:      alu_out = rs1_data_i | op_b;
            XOR:     alu_out = rs1_data_i ^ op_b;
            SLT:     alu_out = {31'd0, $signed(rs1_data_i) < $signed(op_b)};
            PASS_B:  alu_out = op_b;
            default: alu_out = rs1_data_i + op_b;
        endcase
    end

    always_comb begin
        case (dec_i.op)
            JAL, JALR: result_o = pc_i + 32'd4;
            AUIPC:     result_o = pc_i + dec_i.imm;
            default:   result_o = alu_out;
        endcase
    end

    always_comb begin
        case (dec_i.op)
            LOAD, STORE: target_o = rs1_sum;
            JALR:        target_o = {rs1_sum[31:1], 1'b0};
            default:     target_o = pc_i + dec_i.imm;
        endcase
    end

    // Branch comparator
    assign is_eq = (rs1_data_i == rs2_data_i);
    assign is_lt = ($signed(rs1_data_i) < $signed(rs2_data_i));

    always_comb begin
        case (dec_i.funct3)
            3'b000:  taken_o = is_eq;
            3'b001:  taken_o = !is_eq;
            3'b100:  taken_o = is_lt;
            3'b101:  taken_o = !is_lt;
            default: taken_o = 1'b0;
        endcase
        if (dec_i.op != BRANCH) taken_o = 1'b0;
    end

endmodule

`default_nettype wire

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import core_pkg::*; (
    input  logic    clock,
    input  logic    rst_i,
    input  logic    load_i,
    input  inst_t   inst_i,
    output decode_t dec_o
);

    inst_t      ir;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    // Cleared IR decodes as illegal
    always_ff @(posedge clock) begin
        if (rst_i) begin
            ir <= '0;
        end else if (load_i) begin
            ir <= inst_i;
        end
    end

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'h000};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        dec_o.op        = ILLEGAL;
        dec_o.alu_op    = ADD;
        dec_o.rs1       = ir[19:15];
        dec_o.rs2       = ir[24:20];
        dec_o.rd        = ir[11:7];
        dec_o.imm       = imm_i;
        dec_o.funct3    = funct3;
        dec_o.reg_write = 1'b0;
        case (opcode)
            OPC_LUI: begin
                dec_o.op     = LUI;
                dec_o.alu_op = PASS_B;
                dec_o.imm    = imm_u;
            end
            OPC_AUIPC: begin
                dec_o.op  = AUIPC;
                dec_o.imm = imm_u;
            end
            OPC_JAL: begin
                dec_o.op  = JAL;
                dec_o.imm = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) dec_o.op = JALR;
            end
            OPC_BRANCH: begin
                dec_o.imm = imm_b;
                if (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) dec_o.op = BRANCH;
            end
            OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b010, 3'b100}) dec_o.op = LOAD;
            end
            OPC_STORE: begin
                dec_o.imm = imm_s;
                if (funct3 inside {3'b000, 3'b010}) dec_o.op = STORE;
            end
            OPC_OP_IMM, OPC_OP: begin
                case (funct3)
                    3'b000:  dec_o.alu_op = ADD;
                    3'b010:  dec_o.alu_op = SLT;
                    3'b100:  dec_o.alu_op = XOR;
                    3'b110:  dec_o.alu_op = OR;
                    default: dec_o.alu_op = AND;
                endcase
                if (opcode == OPC_OP_IMM) begin
                    if (funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) begin
                        dec_o.op = ALU_IMM;
                    end
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_o.op     = ALU_REG;
                    dec_o.alu_op = SUB;
                end else if (funct7 == 7'b0000000 &&
                             funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) begin
                    dec_o.op = ALU_REG;
                end
            end
            OPC_SYSTEM: begin
                // ecall only
                if (ir == 32'h0000_0073) dec_o.op = SYSTEM;
            end
            default: dec_o.op = ILLEGAL;
        endcase
        dec_o.reg_write = dec_o.op inside {ALU_REG, ALU_IMM, LUI, AUIPC, JAL, JALR, LOAD};
    end

endmodule

`default_nettype wire

/* verilog/lsu_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_align import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_i,
    input  logic     fetch_req_i,
    input  logic     data_req_i,
    input  addr_t    pc_i,
    input  decode_t  dec_i,
    input  addr_t    addr_i,
    input  xlen_t    store_data_i,
    input  xlen_t    result_i,
    input  mem_rsp_t mem_rsp_i,
    output mem_req_t mem_req_o,
    output logic     bus_done_o,
    output inst_t    inst_o,
    output xlen_t    wb_data_o
);

    logic       is_byte;
    logic       is_store;
    xlen_t      load_word;
    logic [7:0] load_byte;
    xlen_t      load_val;

    assign is_byte  = (dec_i.funct3[1:0] == 2'b00);
    assign is_store = data_req_i && (dec_i.op == STORE);

    assign mem_req_o.valid = fetch_req_i || data_req_i;
    assign mem_req_o.we    = is_store;
    assign mem_req_o.addr  = data_req_i ? {addr_i[31:2], 2'b00} : pc_i;
    assign mem_req_o.wdata = is_byte ? {4{store_data_i[7:0]}} : store_data_i;
    assign mem_req_o.strb  = !is_store ? 4'b0000 :
                             is_byte   ? (4'b0001 << addr_i[1:0]) : 4'b1111;

    assign bus_done_o = mem_req_o.valid && mem_rsp_i.ready;
    assign inst_o     = mem_rsp_i.rdata;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            load_word <= '0;
        end else if (data_req_i && !is_store && mem_rsp_i.ready) begin
            load_word <= mem_rsp_i.rdata;
        end
    end

    // Byte lane from the low address bits
    always_comb begin
        case (addr_i[1:0])
            2'd0:    load_byte = load_word[7:0];
            2'd1:    load_byte = load_word[15:8];
            2'd2:    load_byte = load_word[23:16];
            default: load_byte = load_word[31:24];
        endcase
        case (dec_i.funct3)
            3'b000:  load_val = {{24{load_byte[7]}}, load_byte};
            3'b100:  load_val = {24'd0, load_byte};
            default: load_val = load_word;
        endcase
    end

    assign wb_data_o = (dec_i.op == LOAD) ? load_val : result_i;

endmodule

`default_nettype wire

/* verilog/pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_counter import core_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic  clock,
    input  logic  rst_i,
    input  logic  step_i,
    input  logic  jump_i,
    input  addr_t target_i,
    output addr_t pc_o
);

    addr_t pc_q;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (jump_i) begin
            pc_q <= target_i;
        end else if (step_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  logic     wen_i,
    input  xlen_t    wdata_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o
);

    xlen_t regs [0:31];

    always_ff @(posedge clock) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // x0 is hardwired
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire
